// File: Bender.yml
package:
  name: ide_storage_bridge

sources:
  - files:
      - ide_storage_pkg.sv
      - ide_taskfile_pkg.sv
      - ide_sector_buffer.sv
      - ide_host_port.sv
      - ide_command_sequencer.sv
      - ide_storage_bridge.sv
  - target: test
    files:
      - tb_storage_model.sv
      - tb_ide_storage_bridge.sv

// File: ide_command_sequencer.sv
/*
 * Command FSM: opcode decode, sector counting and addressing,
 * buffer routing by direction, storage requests and completion
 */
`timescale 1ns/1ps

module ide_command_sequencer
	import ide_storage_pkg::*, ide_taskfile_pkg::*;
#(
	parameter int sector_words = 256
) (
	input logic clock,
	input logic reset,
	input taskfile_t taskfile,
	input logic command_start,
	output seq_status_t status,
	output logic write_dir,
	input logic host_push,
	input logic host_pop,
	input data_word_t host_push_data,
	output data_word_t host_pop_data,
	output storage_req_t req,
	output logic req_valid,
	input logic req_ready,
	output data_word_t wr_data,
	output logic wr_valid,
	input logic wr_ready,
	input data_word_t rd_data,
	input logic rd_valid,
	output logic rd_ready,
	input storage_done_t done
);

	typedef enum logic [2:0] {
		idle,
		decode,
		host_fill,
		storage_request,
		storage_stream,
		storage_wait,
		host_drain,
		abort
	} seq_state_e;

	seq_state_e state;
	lba_t lba_q; // Address of the sector in flight
	logic [8:0] remaining;
	logic flush;
	logic buf_push;
	logic buf_pop;
	logic buf_full;
	logic buf_empty;
	logic sector_moved;
	data_word_t buf_push_data;
	data_word_t buf_pop_data;

	ide_sector_buffer #(
		.sector_words(sector_words)
	) u_buffer (
		.clock(clock),
		.reset(reset),
		.flush(flush),
		.push(buf_push),
		.pop(buf_pop),
		.push_data(buf_push_data),
		.pop_data(buf_pop_data),
		.full(buf_full),
		.empty(buf_empty)
	);

	// Host fills and storage drains on writes, the reverse on reads
	always_comb begin
		if (write_dir) begin
			buf_push = host_push & status.drq;
			buf_push_data = host_push_data;
			buf_pop = wr_valid & wr_ready;
		end else begin
			buf_push = rd_valid & rd_ready;
			buf_push_data = rd_data;
			buf_pop = host_pop & status.drq;
		end
	end

	assign host_pop_data = buf_pop_data;
	assign wr_data = buf_pop_data;
	assign wr_valid = (state == storage_stream) && write_dir && !buf_empty;
	assign rd_ready = (state == storage_stream) && !write_dir && !buf_full;
	assign req_valid = state == storage_request;
	assign req = '{write: write_dir, lba: lba_q};
	assign flush = (state == decode) || (state == abort);
	assign sector_moved = write_dir ? buf_empty : buf_full;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state <= idle;
			status <= '0;
			write_dir <= 1'b0;
			lba_q <= '0;
			remaining <= '0;
		end else begin
			case (state)
				idle:
					if (command_start) begin
						status.busy <= 1'b1;
						status.err <= 1'b0;
						status.error_code <= 8'h00;
						lba_q <= taskfile.lba;
						remaining <= {taskfile.sector_count == 8'h00, taskfile.sector_count};
						state <= decode;
					end
				decode:
					case (taskfile.opcode)
						READ_SECTORS, READ_SECTORS_RETRY: begin
							write_dir <= 1'b0;
							state <= storage_request;
						end
						WRITE_SECTORS, WRITE_SECTORS_RETRY: begin
							write_dir <= 1'b1;
							status.drq <= 1'b1;
							state <= host_fill;
						end
						default: begin
							status.error_code <= ERR_ABORT;
							state <= abort;
						end
					endcase
				host_fill:
					if (buf_full) begin
						status.drq <= 1'b0;
						state <= storage_request;
					end
				storage_request:
					if (req_ready)
						state <= storage_stream;
				storage_stream, storage_wait:
					if (done.done) begin
						if (done.error) begin
							status.error_code <= ERR_UNCORRECTABLE;
							state <= abort;
						end else begin
							remaining <= remaining - 1'b1;
							lba_q <= lba_q + 1'b1;
							if (!write_dir) begin
								status.drq <= 1'b1; // Sector ready for the host
								state <= host_drain;
							end else if (remaining == 9'd1) begin
								status.busy <= 1'b0;
								state <= idle;
							end else begin
								status.drq <= 1'b1;
								state <= host_fill;
							end
						end
					end else if (state == storage_stream && sector_moved) begin
						state <= storage_wait;
					end
				host_drain:
					if (buf_empty) begin
						status.drq <= 1'b0;
						if (remaining == 9'd0) begin
							status.busy <= 1'b0;
							state <= idle;
						end else begin
							state <= storage_request;
						end
					end
				abort: begin
					status.err <= 1'b1;
					status.drq <= 1'b0;
					status.busy <= 1'b0;
					state <= idle;
				end
				default: state <= idle;
			endcase
		end
	end

endmodule

// File: ide_host_port.sv
/*
 * IDE host side: strobe sampling and edge detection, task-file
 * registers, registered read-back and data register buffer access
 */
`timescale 1ns/1ps

module ide_host_port
	import ide_storage_pkg::*, ide_taskfile_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic cs_n,
	input logic read_n,
	input logic write_n,
	input reg_addr_e address,
	input data_word_t wdata,
	output data_word_t rdata,
	output taskfile_t taskfile,
	output logic command_start,
	input seq_status_t status,
	output logic host_push,
	output logic host_pop,
	output data_word_t host_push_data,
	input data_word_t host_pop_data
);

	reg_addr_e addr_q;
	data_word_t wdata_q;
	logic cs_q;
	logic read_n_q;
	logic write_n_q;
	logic read_edge;
	logic write_commit;
	logic read_commit;
	logic [7:0] features;
	logic lba_mode;
	logic drive_select; // Stored and read back only
	logic [7:0] status_byte;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			addr_q <= REG_DATA;
			cs_q <= 1'b0;
			read_n_q <= 1'b1;
			write_n_q <= 1'b1;
			read_edge <= 1'b0;
		end else begin
			if (!cs_n)
				addr_q <= address;
			cs_q <= !cs_n;
			read_n_q <= read_n;
			write_n_q <= write_n;
			read_edge <= read_n_q & ~read_n; // Falling read strobe
		end
	end

	always_ff @(posedge clock) begin
		if (!cs_n)
			wdata_q <= wdata;
	end

	// Writes take effect on the rising edge of write_n
	assign write_commit = cs_q & ~write_n_q & write_n;
	assign read_commit = cs_q & read_edge;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			taskfile <= '0;
			features <= 8'h00;
			lba_mode <= 1'b0;
			drive_select <= 1'b0;
			command_start <= 1'b0;
		end else begin
			command_start <= 1'b0;
			if (write_commit && !status.busy) begin
				case (addr_q)
					REG_ERROR_FEATURES: features <= wdata_q[7:0];
					REG_SECTOR_COUNT: taskfile.sector_count <= wdata_q[7:0];
					REG_LBA_LOW: taskfile.lba[7:0] <= wdata_q[7:0];
					REG_LBA_MID: taskfile.lba[15:8] <= wdata_q[7:0];
					REG_LBA_HIGH: taskfile.lba[23:16] <= wdata_q[7:0];
					REG_DRIVE_HEAD: begin
						lba_mode <= wdata_q[6];
						drive_select <= wdata_q[4];
						taskfile.lba[27:24] <= wdata_q[3:0];
					end
					REG_STATUS_COMMAND: begin
						taskfile.opcode <= wdata_q[7:0];
						command_start <= 1'b1;
					end
					default: ;
				endcase
			end
		end
	end

	always_comb begin
		status_byte = 8'h00;
		status_byte[STATUS_BSY] = status.busy;
		status_byte[STATUS_DRDY] = ~status.busy;
		status_byte[STATUS_DRQ] = status.drq;
		status_byte[STATUS_ERR] = status.err;
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			rdata <= '0;
		end else if (read_commit) begin
			case (addr_q)
				REG_DATA: rdata <= host_pop_data;
				// Error code while ERR is set, features otherwise
				REG_ERROR_FEATURES: rdata <= {8'h00, status.err ? status.error_code : features};
				REG_SECTOR_COUNT: rdata <= {8'h00, taskfile.sector_count};
				REG_LBA_LOW: rdata <= {8'h00, taskfile.lba[7:0]};
				REG_LBA_MID: rdata <= {8'h00, taskfile.lba[15:8]};
				REG_LBA_HIGH: rdata <= {8'h00, taskfile.lba[23:16]};
				REG_DRIVE_HEAD: rdata <= {8'h00, 1'b1, lba_mode, 1'b1, drive_select,
					taskfile.lba[27:24]};
				REG_STATUS_COMMAND: rdata <= {8'h00, status_byte};
				default: rdata <= '1;
			endcase
		end
	end

	// Data register traffic goes straight to the buffer
	assign host_push = write_commit && (addr_q == REG_DATA);
	assign host_push_data = wdata_q;
	assign host_pop = read_commit && (addr_q == REG_DATA);

endmodule

// File: ide_sector_buffer.sv
/*
 * One-sector circular word FIFO with occupancy count,
 * shared by the read and write directions
 */
`timescale 1ns/1ps

module ide_sector_buffer
	import ide_storage_pkg::*;
#(
	parameter int sector_words = 256
) (
	input logic clock,
	input logic reset,
	input logic flush,
	input logic push,
	input logic pop,
	input data_word_t push_data,
	output data_word_t pop_data,
	output logic full,
	output logic empty
);

	localparam int addr_width = $clog2(sector_words);
	localparam logic [addr_width-1:0] last_addr = addr_width'(sector_words - 1);
	localparam logic [addr_width:0] depth = (addr_width + 1)'(sector_words);

	data_word_t mem [sector_words];
	logic [addr_width-1:0] wr_ptr;
	logic [addr_width-1:0] rd_ptr;
	logic [addr_width:0] count;
	logic push_ok;
	logic pop_ok;

	assign full = count == depth;
	assign empty = count == '0;
	assign push_ok = push & ~full;
	assign pop_ok = pop & ~empty;
	assign pop_data = mem[rd_ptr]; // Oldest word

	always_ff @(posedge clock) begin
		if (push_ok)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else if (flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push_ok)
				wr_ptr <= (wr_ptr == last_addr) ? '0 : wr_ptr + 1'b1;
			if (pop_ok)
				rd_ptr <= (rd_ptr == last_addr) ? '0 : rd_ptr + 1'b1;
			case ({push_ok, pop_ok})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
		end
	end

endmodule

// File: ide_storage_bridge.f
ide_storage_pkg.sv
ide_taskfile_pkg.sv
ide_sector_buffer.sv
ide_host_port.sv
ide_command_sequencer.sv
ide_storage_bridge.sv
tb_storage_model.sv
tb_ide_storage_bridge.sv

// File: ide_storage_bridge.sv
/*
 * IDE PIO to word-stream storage bridge top level:
 * host port and command sequencer
 */
`timescale 1ns/1ps

module ide_storage_bridge
	import ide_storage_pkg::*, ide_taskfile_pkg::*;
#(
	parameter int sector_words = 256
) (
	input logic clock,
	input logic reset,
	input logic cs_n,
	input logic read_n,
	input logic write_n,
	input reg_addr_e address,
	input data_word_t wdata,
	output data_word_t rdata,
	output storage_req_t req,
	output logic req_valid,
	input logic req_ready,
	output data_word_t wr_data,
	output logic wr_valid,
	input logic wr_ready,
	input data_word_t rd_data,
	input logic rd_valid,
	output logic rd_ready,
	input storage_done_t done
);

	taskfile_t taskfile;
	seq_status_t status;
	logic command_start;
	logic host_push;
	logic host_pop;
	data_word_t host_push_data;
	data_word_t host_pop_data;

	ide_host_port u_host_port (
		.clock(clock),
		.reset(reset),
		.cs_n(cs_n),
		.read_n(read_n),
		.write_n(write_n),
		.address(address),
		.wdata(wdata),
		.rdata(rdata),
		.taskfile(taskfile),
		.command_start(command_start),
		.status(status),
		.host_push(host_push),
		.host_pop(host_pop),
		.host_push_data(host_push_data),
		.host_pop_data(host_pop_data)
	);

	ide_command_sequencer #(
		.sector_words(sector_words)
	) u_sequencer (
		.clock(clock),
		.reset(reset),
		.taskfile(taskfile),
		.command_start(command_start),
		.status(status),
		.write_dir(),
		.host_push(host_push),
		.host_pop(host_pop),
		.host_push_data(host_push_data),
		.host_pop_data(host_pop_data),
		.req(req),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.wr_data(wr_data),
		.wr_valid(wr_valid),
		.wr_ready(wr_ready),
		.rd_data(rd_data),
		.rd_valid(rd_valid),
		.rd_ready(rd_ready),
		.done(done)
	);

endmodule

// File: ide_storage_pkg.sv
/*
 * Storage port types: block address and data word widths,
 * the single-sector request struct and the completion struct
 */
package ide_storage_pkg;

	localparam int LBA_WIDTH = 28;
	localparam int WORD_WIDTH = 16;

	typedef logic [LBA_WIDTH-1:0] lba_t;
	typedef logic [WORD_WIDTH-1:0] data_word_t;

	// One request moves exactly one sector
	typedef struct packed {
		logic write; // Set for host-to-storage
		lba_t lba;
	} storage_req_t;

	typedef struct packed {
		logic done; // Single pulse after the last word
		logic error;
	} storage_done_t;

endpackage

// File: ide_taskfile_pkg.sv
/*
 * Task-file definitions: register addresses, supported opcodes,
 * status bit positions, error codes, task-file and status structs
 */
package ide_taskfile_pkg;

	import ide_storage_pkg::*;

	// Command block register offsets
	typedef enum logic [2:0] {
		REG_DATA = 3'd0,
		REG_ERROR_FEATURES = 3'd1,
		REG_SECTOR_COUNT = 3'd2,
		REG_LBA_LOW = 3'd3,
		REG_LBA_MID = 3'd4,
		REG_LBA_HIGH = 3'd5,
		REG_DRIVE_HEAD = 3'd6,
		REG_STATUS_COMMAND = 3'd7
	} reg_addr_e;

	typedef enum logic [7:0] {
		READ_SECTORS = 8'h20,
		READ_SECTORS_RETRY = 8'h21,
		WRITE_SECTORS = 8'h30,
		WRITE_SECTORS_RETRY = 8'h31
	} ata_opcode_e;

	localparam int STATUS_BSY = 7;
	localparam int STATUS_DRDY = 6;
	localparam int STATUS_DRQ = 3;
	localparam int STATUS_ERR = 0;

	localparam logic [7:0] ERR_ABORT = 8'h04; // Command aborted
	localparam logic [7:0] ERR_UNCORRECTABLE = 8'h40; // Media error

	typedef struct packed {
		logic [7:0] sector_count; // Zero means 256
		lba_t lba;
		logic [7:0] opcode;
	} taskfile_t;

	typedef struct packed {
		logic busy;
		logic drq;
		logic err;
		logic [7:0] error_code;
	} seq_status_t;

endpackage

// File: tb_ide_storage_bridge.sv
/*
 * Testbench for the IDE storage bridge: clock, reset, IDE bus tasks,
 * directed tests against the storage model, timeout and summary
 */
`timescale 1ns/1ps

module tb_ide_storage_bridge
	import ide_storage_pkg::*, ide_taskfile_pkg::*;
();

	localparam int sector_words = 16;
	localparam int burst_words = 3 * sector_words;
	// About 240 host words at a status poll plus a data access each (~12 clocks),
	// times four for storage stalls, plus register traffic
	localparam int cycle_limit = 5 * burst_words * 48 + 2000;

	logic clock = 1'b0;
	logic reset;
	logic cs_n;
	logic read_n;
	logic write_n;
	reg_addr_e address;
	data_word_t wdata;
	data_word_t rdata;
	storage_req_t req;
	logic req_valid;
	logic req_ready;
	data_word_t wr_data;
	logic wr_valid;
	logic wr_ready;
	data_word_t rd_data;
	logic rd_valid;
	logic rd_ready;
	storage_done_t done;
	logic [2:0] stall = '0;
	logic stall_enable;
	logic fail_enable;
	lba_t fail_lba;

	logic [31:0] lfsr_state = 32'h8ad8612b;
	data_word_t pattern [burst_words];
	int cycle_count = 0;
	int error_count = 0;
	int test_count = 0;
	int failed_tests = 0;

	ide_storage_bridge #(.sector_words(sector_words)) dut (.*);

	tb_storage_model #(.sector_words(sector_words)) model (.*);

	always #20 clock = ~clock;

	// Galois LFSR, one step per bit taken
	function automatic logic random_bit();
		lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h80200003 : lfsr_state >> 1;
		return lfsr_state[0];
	endfunction

	function automatic data_word_t random_word();
		data_word_t word;
		for (int i = 0; i < 16; i++)
			word[i] = random_bit();
		return word;
	endfunction

	always @(posedge clock) begin
		if (stall_enable)
			stall <= {random_bit(), random_bit(), random_bit()};
		else
			stall <= '0;
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
			$display("** FAIL **");
			$finish;
		end
	end

	task automatic report_error(input string msg);
		$display("ERR at %0d ns: %s", $time, msg);
		error_count++;
	endtask

	task automatic finish_test(input string name, input int errors_before);
		test_count++;
		if (error_count == errors_before) begin
			$display("test %s: passed", name);
		end else begin
			failed_tests++;
			$display("test %s: failed with %0d errors", name, error_count - errors_before);
		end
	endtask

	task automatic bus_write(input reg_addr_e addr, input data_word_t data);
		@(posedge clock);
		cs_n <= 1'b0;
		address <= addr;
		wdata <= data;
		write_n <= 1'b0;
		@(posedge clock);
		write_n <= 1'b1; // Commits on the next clock
		@(posedge clock);
		cs_n <= 1'b1;
	endtask

	task automatic bus_read(input reg_addr_e addr, output data_word_t data);
		@(posedge clock);
		cs_n <= 1'b0;
		address <= addr;
		read_n <= 1'b0;
		repeat (4) @(posedge clock);
		data = rdata;
		read_n <= 1'b1;
		cs_n <= 1'b1;
	endtask

	task automatic wait_drq(output logic ok);
		data_word_t s;
		bus_read(REG_STATUS_COMMAND, s);
		while (!s[STATUS_DRQ] && s[STATUS_BSY])
			bus_read(REG_STATUS_COMMAND, s);
		ok = s[STATUS_DRQ];
	endtask

	task automatic wait_idle(output data_word_t s);
		bus_read(REG_STATUS_COMMAND, s);
		while (s[STATUS_BSY])
			bus_read(REG_STATUS_COMMAND, s);
	endtask

	task automatic issue_command(input lba_t lba, input logic [7:0] count,
		input logic [7:0] opcode);
		bus_write(REG_SECTOR_COUNT, {8'h00, count});
		bus_write(REG_LBA_LOW, {8'h00, lba[7:0]});
		bus_write(REG_LBA_MID, {8'h00, lba[15:8]});
		bus_write(REG_LBA_HIGH, {8'h00, lba[23:16]});
		bus_write(REG_DRIVE_HEAD, {8'h00, 4'he, lba[27:24]}); // LBA mode
		bus_write(REG_STATUS_COMMAND, {8'h00, opcode});
	endtask

	task automatic fill_pattern();
		for (int i = 0; i < burst_words; i++)
			pattern[i] = random_word();
	endtask

	task automatic test_reset_registers();
		reg_addr_e regs [6];
		logic [7:0] values [6];
		logic [7:0] expected;
		data_word_t got;
		int errors_before;
		errors_before = error_count;
		regs = '{REG_SECTOR_COUNT, REG_LBA_LOW, REG_LBA_MID, REG_LBA_HIGH,
			REG_ERROR_FEATURES, REG_DRIVE_HEAD};
		values = '{8'h5a, 8'ha5, 8'h3c, 8'hc3, 8'h69, 8'h5b};
		bus_read(REG_STATUS_COMMAND, got);
		if (got !== 16'h0040)
			report_error($sformatf("status %04h after reset, expected 0040", got));
		for (int i = 0; i < 6; i++)
			bus_write(regs[i], {8'h00, values[i]});
		for (int i = 0; i < 6; i++) begin
			expected = (regs[i] == REG_DRIVE_HEAD) ? (values[i] | 8'ha0) : values[i];
			bus_read(regs[i], got);
			if (got !== {8'h00, expected})
				report_error($sformatf("register %0d read %04h, expected %02h",
					regs[i], got, expected));
		end
		finish_test("reset and registers", errors_before);
	endtask

	task automatic run_transfer(input string name, input lba_t lba, input logic write);
		int errors_before;
		int first_req;
		logic ok;
		data_word_t word;
		lba_t sector_lba;
		storage_req_t logged;
		errors_before = error_count;
		first_req = model.req_count;
		ok = 1'b1;
		issue_command(lba, 8'd3, write ? WRITE_SECTORS : READ_SECTORS);
		for (int i = 0; i < burst_words && ok; i++) begin
			wait_drq(ok);
			if (ok && write) begin
				bus_write(REG_DATA, pattern[i]);
			end else if (ok) begin
				bus_read(REG_DATA, word);
				if (word !== pattern[i])
					report_error($sformatf("word %0d read %04h, expected %04h",
						i, word, pattern[i]));
			end
		end
		if (!ok) begin
			$display("%s: BSY cleared before all %0d words were moved", name, burst_words);
			error_count++;
		end
		wait_idle(word);
		if (word !== 16'h0040)
			report_error($sformatf("final status %04h, expected 0040", word));
		if (model.req_count !== first_req + 3)
			report_error($sformatf("%0d storage requests, expected 3",
				model.req_count - first_req));
		for (int k = 0; k < 3; k++) begin
			sector_lba = lba + k;
			logged = model.req_log[first_req + k];
			if (logged.lba !== sector_lba)
				report_error($sformatf("request %0d for LBA %07h, expected %07h",
					k, logged.lba, sector_lba));
			if (logged.write !== write)
				report_error($sformatf("request %0d has write flag %b, expected %b",
					k, logged.write, write));
			for (int w = 0; w < sector_words && write; w++) begin
				word = model.mem[int'(sector_lba[7:0]) * sector_words + w];
				if (word !== pattern[k * sector_words + w])
					report_error($sformatf("storage word %0d of LBA %07h is %04h, expected %04h",
						w, sector_lba, word, pattern[k * sector_words + w]));
			end
		end
		finish_test(name, errors_before);
	endtask

	task automatic test_unsupported_opcode();
		int errors_before;
		int first_req;
		data_word_t s;
		errors_before = error_count;
		first_req = model.req_count;
		issue_command(28'h0000120, 8'd1, 8'hef);
		wait_idle(s);
		if (s !== 16'h0041)
			report_error($sformatf("status %04h, expected 0041", s));
		bus_read(REG_ERROR_FEATURES, s);
		if (s !== {8'h00, ERR_ABORT})
			report_error($sformatf("error register %04h, expected 0004", s));
		if (model.req_count !== first_req)
			report_error($sformatf("%0d storage requests, expected none",
				model.req_count - first_req));
		finish_test("unsupported opcode", errors_before);
	endtask

	task automatic test_storage_error();
		int errors_before;
		int first_req;
		logic ok;
		data_word_t word;
		storage_req_t logged;
		errors_before = error_count;
		first_req = model.req_count;
		ok = 1'b1;
		@(posedge clock);
		fail_lba <= 28'h0000121;
		fail_enable <= 1'b1;
		issue_command(28'h0000120, 8'd3, READ_SECTORS);
		for (int i = 0; i < sector_words && ok; i++) begin
			wait_drq(ok);
			if (ok) begin
				bus_read(REG_DATA, word);
				if (word !== pattern[i])
					report_error($sformatf("word %0d read %04h, expected %04h",
						i, word, pattern[i]));
			end
		end
		if (!ok) begin
			$display("storage error: BSY cleared before the first sector was read");
			error_count++;
		end
		wait_idle(word);
		if (word !== 16'h0041)
			report_error($sformatf("status %04h, expected 0041", word));
		bus_read(REG_ERROR_FEATURES, word);
		if (word !== {8'h00, ERR_UNCORRECTABLE})
			report_error($sformatf("error register %04h, expected 0040", word));
		if (model.req_count !== first_req + 2)
			report_error($sformatf("%0d storage requests, expected 2",
				model.req_count - first_req));
		for (int k = first_req; k < model.req_count; k++) begin
			logged = model.req_log[k];
			if (logged.lba === 28'h0000122)
				report_error("request issued for LBA 0000122 after the failing sector");
		end
		fail_enable <= 1'b0;
		finish_test("storage error", errors_before);
	endtask

	initial begin
		reset = 1'b1;
		cs_n = 1'b1;
		read_n = 1'b1;
		write_n = 1'b1;
		address = REG_DATA;
		wdata = '0;
		stall_enable = 1'b0;
		fail_enable = 1'b0;
		fail_lba = '0;
		repeat (10) @(posedge clock);
		reset <= 1'b0;
		test_reset_registers();
		fill_pattern();
		run_transfer("write sectors", 28'h0000120, 1'b1);
		run_transfer("read sectors", 28'h0000120, 1'b0);
		test_unsupported_opcode();
		test_storage_error();
		fill_pattern();
		@(posedge clock);
		stall_enable <= 1'b1;
		run_transfer("write with back-pressure", 28'hffffff0, 1'b1);
		run_transfer("read with back-pressure", 28'hffffff0, 1'b0);
		stall_enable <= 1'b0;
		$display("%0d tests run, %0d failed, %0d errors", test_count, failed_tests, error_count);
		if (error_count == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// File: tb_storage_model.sv
/*
 * Behavioral storage device behind the word-stream port:
 * sector memory, request log, stalls and error injection on one LBA
 */
`timescale 1ns/1ps

module tb_storage_model
	import ide_storage_pkg::*;
#(
	parameter int sector_words = 16
) (
	input logic clock,
	input logic reset,
	input logic [2:0] stall, // Holds rd_valid, wr_ready, req_ready
	input logic fail_enable,
	input lba_t fail_lba,
	input storage_req_t req,
	input logic req_valid,
	output logic req_ready,
	input data_word_t wr_data,
	input logic wr_valid,
	output logic wr_ready,
	output data_word_t rd_data,
	output logic rd_valid,
	input logic rd_ready,
	output storage_done_t done
);

	data_word_t mem [256 * sector_words]; // Slot picked by the low LBA byte
	storage_req_t req_log [64];
	int req_count;
	storage_req_t cur;
	logic active;
	int index;
	int slot;
	logic word_moved;

	assign slot = int'(cur.lba[7:0]) * sector_words + index;
	assign req_ready = !active && !stall[0];
	assign wr_ready = active && cur.write && !stall[1];
	assign rd_valid = active && !cur.write && !stall[2];
	assign rd_data = mem[slot];
	assign word_moved = (wr_valid && wr_ready) || (rd_valid && rd_ready);

	initial begin
		for (int i = 0; i < 256 * sector_words; i++)
			mem[i] = data_word_t'(i * 40503) ^ 16'h5a5a; // Unwritten words differ per address
	end

	always @(posedge clock) begin
		if (word_moved && cur.write)
			mem[slot] <= wr_data;
	end

	always @(posedge clock or posedge reset) begin
		if (reset) begin
			cur <= '0;
			active <= 1'b0;
			index <= 0;
			req_count <= 0;
			done <= '0;
		end else begin
			done <= '0;
			if (req_valid && req_ready) begin
				cur <= req;
				active <= 1'b1;
				index <= 0;
				req_log[req_count] <= req;
				req_count <= req_count + 1;
			end
			if (word_moved) begin
				if (index == sector_words - 1) begin
					active <= 1'b0;
					done.done <= 1'b1; // Completion after the last word
					done.error <= fail_enable && (cur.lba == fail_lba);
				end else begin
					index <= index + 1;
				end
			end
		end
	end

endmodule
